//--- Makefile
TOP = tbTop

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --top-module $(TOP) -f all.f -o Vsim
	./obj_dir/Vsim | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- all.f
hw/ulpiPkg.sv
hw/ulpiLinkCtrl.sv
hw/ulpiRegWrite.sv
hw/ulpiRegRead.sv
hw/ulpiRegTop.sv
bench/ulpiPhyModel.sv
bench/tbChecker.sv
bench/tbTop.sv

//--- bench/tbChecker.sv
module tbChecker (
    input logic       clk_ULPI,
    input logic       rst,
    input logic       wbWe,
    input logic [5:0] wbAdr,
    input logic [7:0] wbDatW,
    input logic [7:0] wbDatR,
    input logic       wbAck,
    input logic       wbErr,
    input logic       dir,
    input logic       nxt,
    input logic [7:0] dataO,
    input logic       stp
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] shadow[64];
    string      testName;
    bit         expectErr;
    bit         resetSeen;
    bit         idleChecked;
    bit         cmdChecked;
    bit         bad;
    int         stpCount;
    int         passCount;
    int         failCount;
    logic [7:0] expCmd;

    initial begin
        for (int a = 0; a < 64; a++) shadow[a] = {a[5:0], 2'b10} ^ 8'h3C;  // PHY reset values
        testName = "";
        expectErr = 0;
        resetSeen = 0;
        idleChecked = 0;
        cmdChecked = 0;
        stpCount = 0;
        passCount = 0;
        failCount = 0;
    end

    always @(posedge clk_ULPI) begin
        if (!rst) resetSeen = 1;
        else if (resetSeen && !idleChecked) begin
            idleChecked = 1;                // First cycle out of reset
            if (wbAck !== 1'b0 || wbErr !== 1'b0 || stp !== 1'b0 || dataO !== 8'h00) begin
                $display("[FAIL] after_reset ack %h err %h stp %h dataO %h, expected 0 0 0 00",
                         wbAck, wbErr, stp, dataO);
                failCount++;
            end else passCount++;
            $display("test after_reset done");
        end else if (rst) begin
            expCmd = {1'b1, !wbWe, wbAdr};  // 10 write, 11 read
            // Link must leave the bus alone while the PHY owns it
            if (dir && dataO !== 8'h00) begin
                $display("[FAIL] %s dataO %h while dir high, expected 00", testName, dataO);
                bad = 1;
            end
            if (nxt && !cmdChecked) begin
                cmdChecked = 1;
                if (dataO !== expCmd) begin
                    $display("[FAIL] %s dataO %h, expected %h", testName, dataO, expCmd);
                    bad = 1;
                end
            end
            if (stp) stpCount++;
            if (wbAck || wbErr) begin
                if (expectErr && !wbErr) begin
                    $display("%s: PHY ignored TXCMD but the cycle ended with ack", testName);
                    bad = 1;
                end
                if (!expectErr && !wbAck) begin
                    $display("%s: cycle ended with err instead of ack", testName);
                    bad = 1;
                end
                if (!expectErr && !cmdChecked) begin
                    $display("%s: no TXCMD byte seen while nxt was high", testName);
                    bad = 1;
                end
                if (stpCount != ((wbWe || wbErr) ? 1 : 0)) begin
                    $display("[FAIL] %s stp cycles %h, expected %h", testName, stpCount,
                             (wbWe || wbErr) ? 1 : 0);
                    bad = 1;
                end
                if (wbAck && !wbWe && wbDatR !== shadow[wbAdr]) begin
                    $display("[FAIL] %s wbDatR %h, expected %h", testName, wbDatR,
                             shadow[wbAdr]);
                    bad = 1;
                end
                if (wbAck && wbWe) shadow[wbAdr] = wbDatW;  // Only a taken write counts
                if (bad) failCount++;
                else passCount++;
                $display("test %s %s", testName, bad ? "failed" : "ok");
                bad = 0;
                cmdChecked = 0;
                stpCount = 0;
            end
        end
    end

endmodule

//--- bench/tbTop.sv
module tbTop;
    timeunit 1ns;
    timeprecision 100ps;

    logic       clk_ULPI;
    logic       rst;
    logic       wbCyc;
    logic       wbStb;
    logic       wbWe;
    logic [5:0] wbAdr;
    logic [7:0] wbDatW;
    logic [7:0] wbDatR;
    logic       wbAck;
    logic       wbErr;
    logic       dir;
    logic       nxt;
    logic [7:0] dataI;
    logic [7:0] dataO;
    logic       stp;

    // Stimulus table, one entry per column
    string      names[$];
    bit         rowWe[$];
    logic [5:0] rowAdr[$];
    logic [7:0] rowDat[$];
    int         rowDelay[$];    // PHY NXT delay in cycles
    int         rowBusy[$];     // dir high cycles before the request
    bit         rowIgnore[$];   // PHY never answers TXCMD

    integer     seed = 50604;
    int         waitCnt;
    int         timedOut;
    logic [5:0] bulkAdr;

    ulpiRegTop #(.NxtTimeout(16)) dut (.*);

    ulpiPhyModel phy (.*);

    tbChecker chk (.*);

    task automatic addRow(input string name, input bit we, input logic [5:0] adr,
                          input logic [7:0] dat, input int delay, input int busy,
                          input bit ignore);
        names.push_back(name);
        rowWe.push_back(we);
        rowAdr.push_back(adr);
        rowDat.push_back(dat);
        rowDelay.push_back(delay);
        rowBusy.push_back(busy);
        rowIgnore.push_back(ignore);
    endtask

    initial begin
        clk_ULPI = 1'b0;
        forever #2 clk_ULPI = ~clk_ULPI;   // 4 ns period
    end

    initial begin
        rst    = 1'b0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        timedOut = 0;

        //     name            we  adr    dat    nxt busy ign
        addRow("wr_a05",       1, 6'h05, 8'h3C, 0,  0,  0);
        addRow("rd_a05",       0, 6'h05, 8'h00, 0,  0,  0);
        addRow("rd_a12_reset", 0, 6'h12, 8'h00, 0,  0,  0);
        addRow("wr_a20_nxt1",  1, 6'h20, 8'hA7, 1,  0,  0);
        addRow("rd_a20_nxt3",  0, 6'h20, 8'h00, 3,  0,  0);
        addRow("wr_a21_nxt7",  1, 6'h21, 8'h5E, 7,  0,  0);
        addRow("wr_a22_nxt12", 1, 6'h22, 8'hC3, 12, 0,  0);
        addRow("rd_a22_nxt12", 0, 6'h22, 8'h00, 12, 0,  0);
        addRow("wr_a30_busy",  1, 6'h30, 8'h99, 0,  5,  0);
        addRow("rd_a30_busy",  0, 6'h30, 8'h00, 2,  4,  0);
        addRow("wr_a05_ignore",1, 6'h05, 8'hFF, 0,  0,  1);
        addRow("rd_a05_after", 0, 6'h05, 8'h00, 0,  0,  0);
        addRow("rd_a07_ignore",0, 6'h07, 8'h00, 0,  0,  1);
        for (int i = 0; i < 6; i++) begin  // Bulk pairs, random address and data
            bulkAdr = 6'($random(seed));
            addRow("bulk_wr", 1, bulkAdr, 8'($random(seed)), i % 5, 0, 0);
            addRow("bulk_rd", 0, bulkAdr, 8'h00, (i + 2) % 5, 0, 0);
        end

        repeat (2) @(posedge clk_ULPI);
        #1 rst = 1'b1;
        repeat (2) @(posedge clk_ULPI);

        for (int r = 0; r < names.size(); r++) begin
            #1;
            chk.testName  = names[r];
            chk.expectErr = rowIgnore[r];
            phy.nxtDelay  = rowDelay[r];
            phy.ignoreCmd = rowIgnore[r];
            phy.busyLeft  = rowBusy[r];    // dir rises at the next edge
            @(posedge clk_ULPI);
            #1;
            wbCyc  = 1'b1;
            wbStb  = 1'b1;
            wbWe   = rowWe[r];
            wbAdr  = rowAdr[r];
            wbDatW = rowDat[r];
            waitCnt = 0;
            while (!(wbAck || wbErr) && waitCnt < 200) begin
                @(posedge clk_ULPI);
                waitCnt++;
            end
            if (!(wbAck || wbErr)) begin
                $display("Request %s got neither ack nor err within 200 cycles", names[r]);
                timedOut = 1;
                break;
            end
            #1;
            wbCyc = 1'b0;
            wbStb = 1'b0;
            @(posedge clk_ULPI);
        end

        $display("Tests run %0d, passed %0d, failed %0d",
                 chk.passCount + chk.failCount, chk.passCount, chk.failCount);
        if (timedOut == 0 && chk.failCount == 0 && chk.idleChecked &&
            chk.passCount == names.size() + 1) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/ulpiPhyModel.sv
module ulpiPhyModel (
    input  logic       clk_ULPI,
    input  logic [7:0] dataO,
    input  logic       stp,
    output logic       dir,
    output logic       nxt,
    output logic [7:0] dataI
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum {PhyIdle, PhyAck, PhyWrData, PhyWrStop, PhyRdTurn, PhyRdData} phyStateT;

    logic [7:0] regs[64];
    phyStateT   state;
    logic [7:0] cmdQ;           // TXCMD byte taken with nxt
    logic [7:0] wrData;         // Write value held until STP
    int         waitCnt;
    int         nxtDelay;       // Set per test by the testbench
    int         busyLeft;
    bit         ignoreCmd;

    initial begin
        for (int a = 0; a < 64; a++) regs[a] = {a[5:0], 2'b10} ^ 8'h3C;  // Reset pattern
        state = PhyIdle;
        dir = 1'b0;
        nxt = 1'b0;
        dataI = '0;
        waitCnt = 0;
        nxtDelay = 0;
        busyLeft = 0;
        ignoreCmd = 0;
    end

    always @(posedge clk_ULPI) begin
        case (state)
            PhyIdle: begin
                if (busyLeft > 0) begin
                    dir <= 1'b1;            // Bus held while the link waits
                    busyLeft <= busyLeft - 1;
                end else begin
                    dir <= 1'b0;
                    if (dataO[7] && !ignoreCmd) begin
                        if (waitCnt >= nxtDelay) begin
                            nxt <= 1'b1;
                            state <= PhyAck;
                        end else waitCnt <= waitCnt + 1;
                    end else waitCnt <= 0;
                end
            end
            PhyAck: begin
                cmdQ <= dataO;
                nxt <= 1'b0;
                waitCnt <= 0;
                if (dataO[6]) begin
                    dir <= 1'b1;            // Turnaround for a read
                    state <= PhyRdTurn;
                end else state <= PhyWrData;
            end
            PhyWrData: begin
                wrData <= dataO;
                state <= PhyWrStop;
            end
            PhyWrStop: begin
                if (stp) regs[cmdQ[5:0]] <= wrData;  // Register taken only on STP
                state <= PhyIdle;
            end
            PhyRdTurn: begin
                dataI <= regs[cmdQ[5:0]];
                state <= PhyRdData;
            end
            default: begin
                dir <= 1'b0;
                dataI <= '0;
                state <= PhyIdle;
            end
        endcase
    end

endmodule

//--- hw/ulpiLinkCtrl.sv
module ulpiLinkCtrl import ulpiPkg::*; (
    input  logic     clk_ULPI,  // 60 MHz from PHY
    input  logic     rst,       // Active low, synchronous

    // Wishbone classic slave
    input  logic     wbCyc,
    input  logic     wbStb,
    input  logic     wbWe,
    input  ulpiAddrT wbAdr,
    input  ulpiDataT wbDatW,
    output ulpiDataT wbDatR,    // Valid with ack of a read
    output logic     wbAck,
    output logic     wbErr,

    input  logic     dir,       // PHY owns the bus when high

    // Requests to the engines
    output logic     wrStart,
    output logic     rdStart,
    output ulpiAddrT reqAddr,
    output ulpiDataT reqData,

    // Completions from the engines
    input  logic     wrDone,
    input  logic     wrTimeout,
    input  logic     rdDone,
    input  logic     rdTimeout,
    input  ulpiDataT rdValue,

    // Engine bus drivers, zero when idle
    input  ulpiDataT wrBusOut,
    input  logic     wrBusStp,
    input  ulpiDataT rdBusOut,
    input  logic     rdBusStp,

    // ULPI link outputs
    output ulpiDataT dataO,
    output logic     stp
);

    typedef enum logic [1:0] {
        Idle,                   // No cycle in progress
        Pending,                // Request latched, waiting for a free bus
        Result                  // Engine running, waiting for done or timeout
    } stateT;

    stateT state;
    logic  weQ;                 // Latched direction of the request
    logic  newReq;
    logic  dispatch;
    logic  engDone;
    logic  engFail;

    // Ack or err still high means the master has not dropped stb yet
    assign newReq = wbCyc && wbStb && !wbAck && !wbErr;

    // Engines are idle in Pending since the last one finished before Idle
    assign dispatch = (state == Pending) && wbCyc && !dir;

    assign wrStart = dispatch && weQ;   // One cycle, state leaves Pending
    assign rdStart = dispatch && !weQ;

    assign engDone = wrDone || rdDone;
    assign engFail = wrTimeout || rdTimeout;

    // Request latch
    always_ff @(posedge clk_ULPI) begin
        if ((state == Idle) && newReq) begin
            weQ     <= wbWe;
            reqAddr <= wbAdr;
            reqData <= wbDatW;
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state <= Idle;
            wbAck <= 1'b0;
            wbErr <= 1'b0;
        end else begin
            wbAck <= (state == Result) && engDone;  // Single cycle
            wbErr <= (state == Result) && engFail;
            case (state)
                Idle: begin
                    if (newReq) state <= Pending;
                end
                Pending: begin
                    if (!wbCyc) begin
                        state <= Idle;              // Master gave up
                    end else if (!dir) begin
                        state <= Result;            // Start pulsed this cycle
                    end
                end
                Result: begin
                    if (engDone || engFail) state <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

    // Read engine holds its byte until the next read
    assign wbDatR = rdValue;

    // Only one engine is active at a time, the other drives zero
    assign dataO = wrBusOut | rdBusOut;
    assign stp   = wrBusStp | rdBusStp;

endmodule

//--- hw/ulpiPkg.sv
package ulpiPkg;

    // PHY register address, immediate addressing only
    typedef logic [5:0] ulpiAddrT;

    // One byte on the ULPI data bus
    typedef logic [7:0] ulpiDataT;

    // TXCMD headers, bits [7:6] of the command byte
    localparam logic [1:0] CmdRegWrite = 2'b10; // Immediate register write
    localparam logic [1:0] CmdRegRead  = 2'b11; // Immediate register read

    // Builds the TXCMD byte
    // Header in [7:6], address in [5:0]
    function automatic ulpiDataT txCmdByte(
        input logic [1:0] cmd,
        input ulpiAddrT   addr
    );
        return {cmd, addr};
    endfunction

endpackage

//--- hw/ulpiRegRead.sv
module ulpiRegRead import ulpiPkg::*; #(
    parameter int NxtTimeout = 16   // Cycles on TXCMD before giving up
) (
    input  logic     clk_ULPI,
    input  logic     rst,           // Active low
    input  logic     start,         // One cycle pulse
    input  ulpiAddrT addr,
    input  logic     nxt,
    input  logic     dir,
    input  ulpiDataT dataI,         // PHY to link
    output ulpiDataT busOut,        // Zero when idle
    output logic     busStp,
    output logic     done,
    output logic     timeout,
    output ulpiDataT rdValue        // Last byte read from the PHY
);

    localparam int CntW = $clog2(NxtTimeout + 1);

    typedef enum logic [2:0] {
        Idle,
        TxCmd,      // Read command until nxt
        Turn,       // PHY takes the bus, dir rising
        Capture,    // Register byte on dataI
        Release     // Wait for dir low, or STP after timeout
    } stateT;

    stateT           state;
    ulpiAddrT        addrQ;
    logic            aborted;
    logic [CntW-1:0] waitCnt;
    logic            cntExpired;

    // Same expiry point as the write engine
    assign cntExpired = (waitCnt == CntW'(NxtTimeout - 1));

    always_ff @(posedge clk_ULPI) begin
        if (start) addrQ <= addr;
    end

    // Sample only while the PHY drives the bus
    always_ff @(posedge clk_ULPI) begin
        if ((state == Capture) && dir) rdValue <= dataI;
    end

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state   <= Idle;
            aborted <= 1'b0;
            waitCnt <= '0;
        end else begin
            case (state)
                Idle: begin
                    aborted <= 1'b0;
                    waitCnt <= '0;
                    if (start) state <= TxCmd;
                end
                TxCmd: begin
                    if (nxt) begin
                        state <= Turn;
                    end else if (cntExpired) begin
                        aborted <= 1'b1;
                        state   <= Release;     // STP there, no data
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                Turn:    state <= Capture;      // One turnaround cycle
                Capture: state <= Release;
                Release: begin
                    // PHY must hand the bus back before the next command
                    if (aborted || !dir) state <= Idle;
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(negedge clk_ULPI) begin
        if (!rst) begin
            busOut <= '0;
            busStp <= 1'b0;
        end else begin
            // Link stops driving once the PHY accepts the command
            busOut <= (state == TxCmd) ? txCmdByte(CmdRegRead, addrQ) : '0;
            busStp <= (state == Release) && aborted;
        end
    end

    assign done    = (state == Release) && !aborted && !dir;
    assign timeout = (state == Release) && aborted;

endmodule

//--- hw/ulpiRegTop.sv
module ulpiRegTop import ulpiPkg::*; #(
    parameter int NxtTimeout = 16   // Shared by both engines, 2 or more
) (
    input  logic     clk_ULPI,
    input  logic     rst,

    // Wishbone classic slave
    input  logic     wbCyc,
    input  logic     wbStb,
    input  logic     wbWe,
    input  ulpiAddrT wbAdr,
    input  ulpiDataT wbDatW,
    output ulpiDataT wbDatR,
    output logic     wbAck,
    output logic     wbErr,

    // ULPI link side
    input  logic     dir,
    input  logic     nxt,
    input  ulpiDataT dataI,
    output ulpiDataT dataO,
    output logic     stp
);

    logic     wrStart;
    logic     rdStart;
    ulpiAddrT reqAddr;
    ulpiDataT reqData;
    logic     wrDone;
    logic     wrTimeout;
    logic     rdDone;
    logic     rdTimeout;
    ulpiDataT rdValue;
    ulpiDataT wrBusOut;     // Write engine bus byte
    logic     wrBusStp;
    ulpiDataT rdBusOut;     // Read engine bus byte
    logic     rdBusStp;

    ulpiLinkCtrl ctrl (
        .clk_ULPI  (clk_ULPI),
        .rst       (rst),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .wbErr     (wbErr),
        .dir       (dir),
        .wrStart   (wrStart),
        .rdStart   (rdStart),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .wrDone    (wrDone),
        .wrTimeout (wrTimeout),
        .rdDone    (rdDone),
        .rdTimeout (rdTimeout),
        .rdValue   (rdValue),
        .wrBusOut  (wrBusOut),
        .wrBusStp  (wrBusStp),
        .rdBusOut  (rdBusOut),
        .rdBusStp  (rdBusStp),
        .dataO     (dataO),
        .stp       (stp)
    );

    ulpiRegWrite #(
        .NxtTimeout (NxtTimeout)
    ) regWrite (
        .clk_ULPI (clk_ULPI),
        .rst      (rst),
        .start    (wrStart),
        .addr     (reqAddr),
        .data     (reqData),
        .nxt      (nxt),
        .busOut   (wrBusOut),
        .busStp   (wrBusStp),
        .done     (wrDone),
        .timeout  (wrTimeout)
    );

    ulpiRegRead #(
        .NxtTimeout (NxtTimeout)
    ) regRead (
        .clk_ULPI (clk_ULPI),
        .rst      (rst),
        .start    (rdStart),
        .addr     (reqAddr),
        .nxt      (nxt),
        .dir      (dir),
        .dataI    (dataI),
        .busOut   (rdBusOut),
        .busStp   (rdBusStp),
        .done     (rdDone),
        .timeout  (rdTimeout),
        .rdValue  (rdValue)
    );

endmodule

//--- hw/ulpiRegWrite.sv
module ulpiRegWrite import ulpiPkg::*; #(
    parameter int NxtTimeout = 16   // Cycles on TXCMD before giving up
) (
    input  logic     clk_ULPI,
    input  logic     rst,           // Active low
    input  logic     start,         // One cycle pulse
    input  ulpiAddrT addr,
    input  ulpiDataT data,
    input  logic     nxt,
    output ulpiDataT busOut,        // Zero when idle
    output logic     busStp,
    output logic     done,
    output logic     timeout
);

    localparam int CntW = $clog2(NxtTimeout + 1);

    typedef enum logic [1:0] {
        Idle,
        TxCmd,      // Command byte until nxt
        Data,       // Register value for one cycle
        Stop        // STP for one cycle
    } stateT;

    stateT           state;
    ulpiAddrT        addrQ;
    ulpiDataT        dataQ;
    logic            aborted;       // Stop reached through timeout
    logic [CntW-1:0] waitCnt;       // Cycles spent in TxCmd
    logic            cntExpired;

    assign cntExpired = (waitCnt == CntW'(NxtTimeout - 1));

    always_ff @(posedge clk_ULPI) begin
        if (start) begin
            addrQ <= addr;
            dataQ <= data;
        end
    end

    always_ff @(posedge clk_ULPI) begin
        if (!rst) begin
            state   <= Idle;
            aborted <= 1'b0;
            waitCnt <= '0;
        end else begin
            case (state)
                Idle: begin
                    aborted <= 1'b0;
                    waitCnt <= '0;
                    if (start) state <= TxCmd;
                end
                TxCmd: begin
                    if (nxt) begin
                        state <= Data;          // PHY took the command
                    end else if (cntExpired) begin
                        aborted <= 1'b1;
                        state   <= Stop;
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                Data:    state <= Stop;         // Data nxt not checked
                Stop:    state <= Idle;
                default: state <= Idle;
            endcase
        end
    end

    // Bus outputs change on the falling edge, stable at the PHY's sample
    always_ff @(negedge clk_ULPI) begin
        if (!rst) begin
            busOut <= '0;
            busStp <= 1'b0;
        end else begin
            case (state)
                TxCmd:   busOut <= txCmdByte(CmdRegWrite, addrQ);
                Data:    busOut <= dataQ;
                default: busOut <= '0;
            endcase
            busStp <= (state == Stop);
        end
    end

    assign done    = (state == Stop) && !aborted;
    assign timeout = (state == Stop) && aborted;

endmodule
